/* source/branch_pkg.sv */
`default_nettype none

package branch_pkg;

    // Instruction field positions
    localparam int opcode_msb = 31;
    localparam int opcode_lsb = 26;
    localparam int funct_msb  = 5;
    localparam int funct_lsb  = 0;

    // Conditional branch opcodes
    localparam logic [5:0] op_beq    = 6'h04;
    localparam logic [5:0] op_bne    = 6'h05;
    localparam logic [5:0] op_blez   = 6'h06;
    localparam logic [5:0] op_bgtz   = 6'h07;
    localparam logic [5:0] op_regimm = 6'h01;

    // Direct jumps, and the SPECIAL opcode that carries jr in its funct field
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] funct_jr   = 6'h08;

    // 2-bit counter encodings, the upper bit is the prediction
    localparam logic [1:0] ctr_strong_not_taken = 2'b00;
    localparam logic [1:0] ctr_weak_not_taken   = 2'b01;
    localparam logic [1:0] ctr_weak_taken       = 2'b10;
    localparam logic [1:0] ctr_strong_taken     = 2'b11;

    // Chooser uses the same encoding: 2 and 3 select the global predictor
    localparam logic [1:0] ctr_weak_local = 2'b01;

    // Word-aligned PCs, so the two low bits never index anything
    localparam int pc_lsb = 2;

endpackage

`default_nettype wire

/* source/branch_decoder.sv */
`default_nettype none

module branch_decoder (
    input  logic [31:0] instr,
    output logic        branch,
    output logic        jump
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[branch_pkg::opcode_msb:branch_pkg::opcode_lsb];
    assign funct  = instr[branch_pkg::funct_msb:branch_pkg::funct_lsb];

    always_comb begin
        branch = 1'b0;
        jump   = 1'b0;
        case (opcode)
            branch_pkg::op_beq,
            branch_pkg::op_bne,
            branch_pkg::op_blez,
            branch_pkg::op_bgtz,
            branch_pkg::op_regimm: begin
                branch = 1'b1;
            end
            branch_pkg::op_j,
            branch_pkg::op_jal: begin
                jump = 1'b1;
            end
            branch_pkg::op_special: begin
                // Only jr counts; other R-type words fall through as non-branches
                jump = (funct == branch_pkg::funct_jr);
            end
            default: begin
                branch = 1'b0;
                jump   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/counter_table.sv */
`default_nettype none

module counter_table #(
    parameter int         depth_bits  = 6,
    parameter logic [1:0] reset_value = branch_pkg::ctr_weak_not_taken
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic [depth_bits-1:0] read_index,
    output logic                  read_taken,
    output logic [1:0]            read_counter,
    input  logic                  update,
    input  logic [depth_bits-1:0] update_index,
    input  logic                  update_up,
    input  logic                  update_down
);

    localparam int depth = 2 ** depth_bits;

    logic [1:0] counters [depth];
    logic [1:0] current;

    // Combinational read, upper bit is the taken prediction
    assign read_counter = counters[read_index];
    assign read_taken   = read_counter[1];

    assign current = counters[update_index];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < depth; i++) begin
                counters[i] <= reset_value;
            end
        end else if (update) begin
            // Saturate at both ends
            if (update_up && current != branch_pkg::ctr_strong_taken) begin
                counters[update_index] <= current + 2'd1;
            end else if (update_down && current != branch_pkg::ctr_strong_not_taken) begin
                counters[update_index] <= current - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/local_predictor.sv */
`default_nettype none

module local_predictor #(
    parameter int index_bits = 6,
    parameter int hist_bits  = 4
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic [31:0] lookup_addr,
    output logic        taken,
    input  logic        update,
    input  logic [31:0] update_addr,
    input  logic        outcome
);

    localparam int depth = 2 ** index_bits;

    logic [hist_bits-1:0]  history [depth];
    logic [index_bits-1:0] lookup_index;
    logic [index_bits-1:0] update_index;
    logic [hist_bits-1:0]  lookup_hist;
    logic [hist_bits-1:0]  update_hist;

    assign lookup_index = lookup_addr[branch_pkg::pc_lsb +: index_bits];
    assign update_index = update_addr[branch_pkg::pc_lsb +: index_bits];

    assign lookup_hist = history[lookup_index];
    assign update_hist = history[update_index];

    // Per-branch history shifts in the resolved outcome, newest in bit 0
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < depth; i++) begin
                history[i] <= '0;
            end
        end else if (update) begin
            history[update_index] <= {update_hist[hist_bits-2:0], outcome};
        end
    end

    // Pattern counters, trained under the history seen before this update
    counter_table #(
        .depth_bits  (hist_bits),
        .reset_value (branch_pkg::ctr_weak_not_taken)
    ) pattern_i (
        .CLK          (CLK),
        .RESET        (RESET),
        .read_index   (lookup_hist),
        .read_taken   (taken),
        .read_counter (),
        .update       (update),
        .update_index (update_hist),
        .update_up    (outcome),
        .update_down  (!outcome)
    );

endmodule

`default_nettype wire

/* source/global_predictor.sv */
`default_nettype none

module global_predictor #(
    parameter int index_bits = 6,
    parameter int ghr_bits   = 6
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic [31:0] lookup_addr,
    output logic        taken,
    input  logic        update,
    input  logic [31:0] update_addr,
    input  logic        outcome
);

    logic [ghr_bits-1:0]   ghr;
    logic [index_bits-1:0] ghr_wide;
    logic [index_bits-1:0] lookup_index;
    logic [index_bits-1:0] update_index;

    // GHR is zero-extended into the low index bits (ghr_bits <= index_bits)
    assign ghr_wide = index_bits'(ghr);

    assign lookup_index = lookup_addr[branch_pkg::pc_lsb +: index_bits] ^ ghr_wide;
    assign update_index = update_addr[branch_pkg::pc_lsb +: index_bits] ^ ghr_wide;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ghr <= '0;
        end else if (update) begin
            ghr <= {ghr[ghr_bits-2:0], outcome};
        end
    end

    counter_table #(
        .depth_bits  (index_bits),
        .reset_value (branch_pkg::ctr_weak_not_taken)
    ) gshare_i (
        .CLK          (CLK),
        .RESET        (RESET),
        .read_index   (lookup_index),
        .read_taken   (taken),
        .read_counter (),
        .update       (update),
        .update_index (update_index),
        .update_up    (outcome),
        .update_down  (!outcome)
    );

endmodule

`default_nettype wire

/* source/branch_target_buffer.sv */
`default_nettype none

module branch_target_buffer #(
    parameter int index_bits = 6
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        flush,
    input  logic [31:0] lookup_addr,
    output logic        hit,
    output logic [31:0] target,
    input  logic        update,
    input  logic [31:0] update_addr,
    input  logic [31:0] update_target
);

    localparam int depth    = 2 ** index_bits;
    localparam int tag_lsb  = branch_pkg::pc_lsb + index_bits;
    localparam int tag_bits = 32 - tag_lsb;

    logic [tag_bits-1:0]   tags    [depth];
    logic [31:0]           targets [depth];
    logic [depth-1:0]      valid;

    logic [index_bits-1:0] lookup_index;
    logic [tag_bits-1:0]   lookup_tag;
    logic [index_bits-1:0] update_index;
    logic [tag_bits-1:0]   update_tag;

    assign lookup_index = lookup_addr[branch_pkg::pc_lsb +: index_bits];
    assign lookup_tag   = lookup_addr[31:tag_lsb];
    assign update_index = update_addr[branch_pkg::pc_lsb +: index_bits];
    assign update_tag   = update_addr[31:tag_lsb];

    // Hit needs a live entry whose tag matches the fetch PC
    assign hit    = valid[lookup_index] && (tags[lookup_index] == lookup_tag);
    assign target = targets[lookup_index];

    // Valid bits, the only state that reset and flush touch
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (update) begin
            valid[update_index] <= 1'b1;
        end
    end

    // Tag and target payload
    always_ff @(posedge CLK) begin
        if (update && !flush) begin
            tags[update_index]    <= update_tag;
            targets[update_index] <= update_target;
        end
    end

endmodule

`default_nettype wire

/* source/hybrid_predictor.sv */
`default_nettype none

module hybrid_predictor #(
    parameter int index_bits = 6,
    parameter int hist_bits  = 4,
    parameter int ghr_bits   = 6
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        flush,
    input  logic [31:0] instr,
    input  logic [31:0] instr_addr,
    input  logic [31:0] mem_instr,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_target,
    input  logic        mem_resolved,
    input  logic [1:0]  mem_predictions,
    output logic        taken,
    output logic [31:0] taken_addr,
    output logic [1:0]  predictions
);

    logic                  fetch_branch;
    logic                  fetch_jump;
    logic                  mem_branch;
    logic                  mem_jump;
    logic                  resolving;
    logic                  global_right;
    logic                  local_right;
    logic                  chooser_up;
    logic                  chooser_down;
    logic                  use_global;
    logic                  local_taken;
    logic                  global_taken;
    logic                  btb_hit;
    logic [31:0]           btb_target;
    logic                  predict_taken;
    logic [index_bits-1:0] fetch_index;
    logic [index_bits-1:0] mem_index;

    branch_decoder fetch_decoder_i (
        .instr  (instr),
        .branch (fetch_branch),
        .jump   (fetch_jump)
    );

    branch_decoder mem_decoder_i (
        .instr  (mem_instr),
        .branch (mem_branch),
        .jump   (mem_jump)
    );

    // All training is gated by the MEM-stage word being a branch or jump
    assign resolving = mem_branch | mem_jump;

    // Chooser leans toward whichever side alone was right
    assign global_right = (mem_predictions[1] == mem_resolved);
    assign local_right  = (mem_predictions[0] == mem_resolved);
    assign chooser_up   = global_right & ~local_right;
    assign chooser_down = local_right & ~global_right;

    assign fetch_index = instr_addr[branch_pkg::pc_lsb +: index_bits];
    assign mem_index   = mem_addr[branch_pkg::pc_lsb +: index_bits];

    local_predictor #(
        .index_bits (index_bits),
        .hist_bits  (hist_bits)
    ) local_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .lookup_addr (instr_addr),
        .taken       (local_taken),
        .update      (resolving),
        .update_addr (mem_addr),
        .outcome     (mem_resolved)
    );

    global_predictor #(
        .index_bits (index_bits),
        .ghr_bits   (ghr_bits)
    ) global_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .lookup_addr (instr_addr),
        .taken       (global_taken),
        .update      (resolving),
        .update_addr (mem_addr),
        .outcome     (mem_resolved)
    );

    counter_table #(
        .depth_bits  (index_bits),
        .reset_value (branch_pkg::ctr_weak_local)
    ) chooser_i (
        .CLK          (CLK),
        .RESET        (RESET),
        .read_index   (fetch_index),
        .read_taken   (use_global),
        .read_counter (),
        .update       (resolving),
        .update_index (mem_index),
        .update_up    (chooser_up),
        .update_down  (chooser_down)
    );

    // Only taken resolutions allocate a BTB entry
    branch_target_buffer #(
        .index_bits (index_bits)
    ) btb_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .flush         (flush),
        .lookup_addr   (instr_addr),
        .hit           (btb_hit),
        .target        (btb_target),
        .update        (resolving & mem_resolved),
        .update_addr   (mem_addr),
        .update_target (mem_target)
    );

    assign predict_taken = (use_global ? global_taken : local_taken)
                           & btb_hit & (fetch_branch | fetch_jump);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            taken       <= 1'b0;
            taken_addr  <= '0;
            predictions <= '0;
        end else if (flush) begin
            taken       <= 1'b0;
            taken_addr  <= '0;
            predictions <= '0;
        end else begin
            taken       <= predict_taken;
            taken_addr  <= btb_target;
            predictions <= {global_taken, local_taken};
        end
    end

endmodule

`default_nettype wire

/* tb/hybrid_predictor_properties.sv */
`default_nettype none

module hybrid_predictor_properties (
    input logic        CLK,
    input logic        RESET,
    input logic        flush,
    input logic        taken,
    input logic [31:0] taken_addr,
    input logic [1:0]  predictions
);

    int failures;

    initial failures = 0;

    // A predicted target is always a word address
    target_aligned: assert property (
        @(posedge CLK) disable iff (!RESET)
        taken |-> taken_addr[1:0] == 2'b00
    ) else begin
        $error("taken_addr %h is not word aligned", taken_addr);
        failures++;
    end

    // First edge after release still shows the reset values
    reset_clear: assert property (
        @(posedge CLK)
        $rose(RESET) |-> !taken && taken_addr == '0 && predictions == '0
    ) else begin
        $error("outputs not cleared after reset");
        failures++;
    end

    flush_clear: assert property (
        @(posedge CLK) disable iff (!RESET)
        flush |=> !taken
    ) else begin
        $error("taken high one cycle after a flush");
        failures++;
    end

endmodule

bind hybrid_predictor hybrid_predictor_properties properties_i (
    .CLK         (CLK),
    .RESET       (RESET),
    .flush       (flush),
    .taken       (taken),
    .taken_addr  (taken_addr),
    .predictions (predictions)
);

`default_nettype wire

/* tb/hybrid_predictor_tb.sv */
`default_nettype none

module hybrid_predictor_tb;

    localparam int index_bits  = 6;
    localparam int hist_bits   = 4;
    localparam int ghr_bits    = 6;
    localparam int drive_delay = 2;
    localparam int cycle_limit = 2000;

    logic        CLK;
    logic        RESET;
    logic        flush;
    logic [31:0] instr;
    logic [31:0] instr_addr;
    logic [31:0] mem_instr;
    logic [31:0] mem_addr;
    logic [31:0] mem_target;
    logic        mem_resolved;
    logic [1:0]  mem_predictions;
    logic        taken;
    logic [31:0] taken_addr;
    logic [1:0]  predictions;

    integer      seed;
    int          errors;
    int          checks;
    int          tests;
    int          test_start_errors;
    logic [31:0] br_addr;
    logic [31:0] br_target;
    logic [31:0] br_word;
    logic [31:0] jmp_addr;
    logic [31:0] jmp_target;
    logic [31:0] jmp_word;
    logic [31:0] alu_word;

    hybrid_predictor #(
        .index_bits (index_bits),
        .hist_bits  (hist_bits),
        .ghr_bits   (ghr_bits)
    ) dut_i (
        .CLK             (CLK),
        .RESET           (RESET),
        .flush           (flush),
        .instr           (instr),
        .instr_addr      (instr_addr),
        .mem_instr       (mem_instr),
        .mem_addr        (mem_addr),
        .mem_target      (mem_target),
        .mem_resolved    (mem_resolved),
        .mem_predictions (mem_predictions),
        .taken           (taken),
        .taken_addr      (taken_addr),
        .predictions     (predictions)
    );

    always #20 CLK = ~CLK;

    function automatic logic [31:0] make_word(input logic [5:0] opcode, input logic [25:0] rest);
        logic [31:0] word;
        word = {6'b0, rest};
        word[branch_pkg::opcode_msb:branch_pkg::opcode_lsb] = opcode;
        return word;
    endfunction

    task automatic next_cycle;
        @(posedge CLK);
        #drive_delay;
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    // One fetch, with MEM idle; the prediction is registered at the next edge
    task automatic lookup(input logic [31:0] word, input logic [31:0] addr);
        instr      = word;
        instr_addr = addr;
        mem_instr  = '0;
        next_cycle();
    endtask

    // Fetch the branch, then resolve it with the pair the DUT predicted for it
    task automatic resolve(input logic [31:0] word, input logic [31:0] addr,
                           input logic [31:0] target, input logic outcome,
                           output logic [1:0] pair);
        lookup(word, addr);
        pair            = predictions;
        mem_instr       = word;
        mem_addr        = addr;
        mem_target      = target;
        mem_resolved    = outcome;
        mem_predictions = pair;
        next_cycle();
        mem_instr = '0;
    endtask

    task automatic train(input logic [31:0] word, input logic [31:0] addr,
                         input logic [31:0] target, input logic outcome, input int count);
        logic [1:0] pair;
        for (int i = 0; i < count; i++) begin
            resolve(word, addr, target, outcome, pair);
        end
    endtask

    task automatic expect_prediction(input logic [31:0] word, input logic [31:0] addr,
                                     input logic exp_taken, input logic [1:0] exp_pred);
        lookup(word, addr);
        compare("taken", taken, exp_taken);
        compare("predictions", predictions, exp_pred);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("%s finished with %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic cold_lookup;
        expect_prediction(br_word, br_addr, 1'b0, 2'b00);
        expect_prediction(jmp_word, jmp_addr, 1'b0, 2'b00);
        finish_test("cold_lookup");
    endtask

    // GHR needs ghr_bits taken outcomes to reach all ones, then two more saturate its counter
    task automatic taken_training;
        train(br_word, br_addr, br_target, 1'b1, ghr_bits + 2);
        expect_prediction(br_word, br_addr, 1'b1, 2'b11);
        compare("taken_addr", taken_addr, br_target);
        finish_test("taken_training");
    endtask

    task automatic non_branch_lookup;
        expect_prediction(alu_word, br_addr, 1'b0, 2'b11);
        finish_test("non_branch_lookup");
    endtask

    // History ends at 0 where the local counter was driven down, GHR ends at 0 where
    // gshare still holds the taken count from the first training step; chooser leans local
    task automatic not_taken_training;
        train(br_word, br_addr, br_target, 1'b0, hist_bits + 2);
        expect_prediction(br_word, br_addr, 1'b0, 2'b10);
        compare("taken_addr", taken_addr, br_target);
        finish_test("not_taken_training");
    endtask

    task automatic flush_recovery;
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        // The stale target and pair of the last lookup must be gone
        compare("taken after flush", taken, 1'b0);
        compare("taken_addr after flush", taken_addr, 32'h0);
        compare("predictions after flush", predictions, 2'b00);
        expect_prediction(br_word, br_addr, 1'b0, 2'b10);
        // Global alone was right, so the chooser now moves to global
        train(br_word, br_addr, br_target, 1'b1, 1);
        expect_prediction(br_word, br_addr, 1'b1, 2'b11);
        compare("taken_addr", taken_addr, br_target);
        finish_test("flush_recovery");
    endtask

    task automatic jump_training;
        lookup(jmp_word, jmp_addr);
        compare("taken", taken, 1'b0);
        train(jmp_word, jmp_addr, jmp_target, 1'b1, 1);
        train(jmp_word, jmp_addr, jmp_target, 1'b1, hist_bits + 2);
        expect_prediction(jmp_word, jmp_addr, 1'b1, 2'b11);
        compare("taken_addr", taken_addr, jmp_target);
        finish_test("jump_training");
    endtask

    initial begin
        seed              = 32'hea41;
        CLK               = 1'b0;
        RESET             = 1'b0;
        flush             = 1'b0;
        instr             = '0;
        instr_addr        = '0;
        mem_instr         = '0;
        mem_addr          = '0;
        mem_target        = '0;
        mem_resolved      = 1'b0;
        mem_predictions   = '0;
        errors            = 0;
        checks            = 0;
        tests             = 0;
        test_start_errors = 0;

        br_addr    = $random(seed) & ~32'h3;
        jmp_addr   = $random(seed) & ~32'h3;
        // Keep the two PCs in different table rows
        if (jmp_addr[branch_pkg::pc_lsb +: index_bits] == br_addr[branch_pkg::pc_lsb +: index_bits])
            jmp_addr = jmp_addr ^ 32'h4;
        br_target  = $random(seed) & ~32'h3;
        jmp_target = $random(seed) & ~32'h3;
        br_word    = make_word(branch_pkg::op_beq, 26'($random(seed)));
        jmp_word   = make_word(branch_pkg::op_j, 26'($random(seed)));
        // R-type add
        alu_word   = make_word(branch_pkg::op_special, 26'h20);

        repeat (10) @(posedge CLK);
        #drive_delay;
        RESET = 1'b1;

        cold_lookup();
        taken_training();
        non_branch_lookup();
        not_taken_training();
        flush_recovery();
        jump_training();

        // Fold in failures of the bound concurrent assertions
        errors = errors + dut_i.properties_i.failures;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* hybrid_predictor.f */
source/branch_pkg.sv
source/branch_decoder.sv
source/counter_table.sv
source/local_predictor.sv
source/global_predictor.sv
source/branch_target_buffer.sv
source/hybrid_predictor.sv
tb/hybrid_predictor_properties.sv
tb/hybrid_predictor_tb.sv

/* Bender.yml */
package:
  name: hybrid_predictor

sources:
  - source/branch_pkg.sv
  - source/branch_decoder.sv
  - source/counter_table.sv
  - source/local_predictor.sv
  - source/global_predictor.sv
  - source/branch_target_buffer.sv
  - source/hybrid_predictor.sv
  - target: test
    files:
      - tb/hybrid_predictor_properties.sv
      - tb/hybrid_predictor_tb.sv
